//--- source/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NWAY     = 2;
    localparam int LINE_W   = 8 << OFFSET_W;

    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [31:0]              word_t;
    typedef logic [3:0]               strb_t;
    typedef logic [LINE_W-1:0]        line_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [$clog2(NWAY)-1:0]  way_t;

    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // wstrb of zero marks a load
    typedef struct packed {
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        way_t  way;
        logic  dirty;
        line_t line;
    } refill_t;

    typedef enum logic [2:0] {
        IDLE,
        EVICT_REQ,
        EVICT_WAIT,
        REFILL_REQ,
        REFILL_WAIT
    } miss_state_t;

    // strobed bytes of wdata land in the word slot picked by addr[3:2]
    function automatic line_t merge_store(line_t line, addr_t addr, strb_t strb, word_t wdata);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[int'(addr[3:2]) * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- source/dcache_way_ram.sv
`timescale 1ns/1ps

module dcache_way_ram import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  index_t     rd_index_i,
    input  logic       wr_en_i,
    input  index_t     wr_index_i,
    input  logic       tag_we_i,
    input  tag_entry_t tag_i,
    input  logic [15:0] byte_we_i,
    input  line_t      line_i,
    output tag_entry_t tag_o,
    output line_t      line_o,
    output logic       init_busy_o
);

    localparam int NSET = 1 << INDEX_W;

    tag_entry_t tag_mem [NSET];
    line_t      data_mem [NSET];

    logic       init_busy;
    index_t     init_index;
    logic       tag_wr;
    index_t     tag_wr_index;
    tag_entry_t tag_wr_data;
    tag_entry_t rd_tag;
    line_t      rd_line;

    // the valid sweep owns the tag port until every set is cleared
    assign tag_wr       = init_busy || (wr_en_i && tag_we_i);
    assign tag_wr_index = init_busy ? init_index : wr_index_i;
    assign tag_wr_data  = init_busy ? '0 : tag_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            init_busy  <= 1'b1;
            init_index <= '0;
        end else if (init_busy) begin
            init_index <= init_index + 1'b1;
            if (init_index == '1) begin
                init_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[tag_wr_index] <= tag_wr_data;
        end
        if (wr_en_i) begin
            for (int b = 0; b < 16; b++) begin
                if (byte_we_i[b]) begin
                    data_mem[wr_index_i][b * 8 +: 8] <= line_i[b * 8 +: 8];
                end
            end
        end
    end

    // write-first: a read of the set being written sees the new bytes
    always_comb begin
        rd_tag  = tag_mem[rd_index_i];
        rd_line = data_mem[rd_index_i];
        if (tag_wr && tag_wr_index == rd_index_i) begin
            rd_tag = tag_wr_data;
        end
        if (wr_en_i && wr_index_i == rd_index_i) begin
            for (int b = 0; b < 16; b++) begin
                if (byte_we_i[b]) begin
                    rd_line[b * 8 +: 8] = line_i[b * 8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_o  <= rd_tag;
        line_o <= rd_line;
    end

    assign init_busy_o = init_busy;

endmodule

//--- source/dcache_pipeline.sv
`timescale 1ns/1ps

module dcache_pipeline import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  cpu_req_t               req_i,
    output logic                   ready_o,
    output logic                   data_ok_o,
    output word_t                  rdata_o,
    input  logic                   busy_i,
    input  refill_t                refill_i,
    output logic                   s3_miss_o,
    output cpu_req_t               s3_req_o,
    output tag_entry_t [NWAY-1:0]  s3_tags_o,
    output line_t [NWAY-1:0]       s3_lines_o
);

    logic                  s1_valid, s2_valid, s3_valid;
    cpu_req_t              s1_req, s2_req, s3_req;
    logic [NWAY-1:0]       s2_hit, s3_hit;
    tag_entry_t [NWAY-1:0] s3_tags;
    line_t [NWAY-1:0]      s3_lines;

    tag_entry_t [NWAY-1:0] ram_tag;
    line_t [NWAY-1:0]      ram_line;
    logic [NWAY-1:0]       ram_init_busy;
    logic [NWAY-1:0]       ram_wr_en;
    logic [NWAY-1:0]       ram_tag_we;
    index_t                ram_rd_index;
    tag_entry_t            ram_tag_wdata;
    logic [15:0]           ram_byte_we;
    line_t                 ram_line_wdata;

    logic   stall;
    logic   s3_any_hit;
    logic   s3_store;
    logic   s3_store_hit;
    way_t   hit_way;
    line_t  hit_line;
    index_t s3_index;

    assign s3_any_hit   = |s3_hit;
    assign s3_store     = |s3_req.wstrb;
    assign s3_store_hit = s3_valid && s3_any_hit && s3_store;
    assign hit_way      = s3_hit[1];
    assign hit_line     = s3_lines[hit_way];
    assign s3_index     = s3_req.addr[OFFSET_W +: INDEX_W];

    // a store hit takes the array write port, so the input waits one cycle
    assign stall   = busy_i || s3_store_hit || (|ram_init_busy);
    assign ready_o = !stall;

    // on a stall the arrays re-read the held stage-2 set to pick up fresh writes
    assign ram_rd_index = stall ? s2_req.addr[OFFSET_W +: INDEX_W]
                                : s1_req.addr[OFFSET_W +: INDEX_W];

    // tag compare in stage 2
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            s2_hit[w] = ram_tag[w].valid && (ram_tag[w].tag == s2_req.addr[ADDR_W-1 -: TAG_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req_valid_i;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end else if (s3_store_hit || refill_i.valid) begin
            // stage 3 retires while the earlier stages hold
            s3_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_req   <= req_i;
            s2_req   <= s1_req;
            s3_req   <= s2_req;
            s3_hit   <= s2_hit;
            s3_tags  <= ram_tag;
            s3_lines <= ram_line;
        end
    end

    // array writes come from a store hit or a refill, both at the stage-3 set
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            ram_wr_en[w] = (s3_store_hit && hit_way == way_t'(w))
                        || (refill_i.valid && refill_i.way == way_t'(w));
            // a line that is already dirty needs no tag update on a store
            ram_tag_we[w] = refill_i.valid || !s3_tags[w].dirty;
        end
        if (refill_i.valid) begin
            ram_tag_wdata  = '{dirty: refill_i.dirty, valid: 1'b1,
                               tag: s3_req.addr[ADDR_W-1 -: TAG_W]};
            ram_byte_we    = '1;
            ram_line_wdata = refill_i.line;
        end else begin
            ram_tag_wdata  = '{dirty: 1'b1, valid: 1'b1, tag: s3_req.addr[ADDR_W-1 -: TAG_W]};
            ram_byte_we    = 16'(s3_req.wstrb) << {s3_req.addr[3:2], 2'b00};
            ram_line_wdata = {4{s3_req.wdata}};
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        dcache_way_ram u_way_ram (
            .clk         (clk),
            .rst         (rst),
            .rd_index_i  (ram_rd_index),
            .wr_en_i     (ram_wr_en[w]),
            .wr_index_i  (s3_index),
            .tag_we_i    (ram_tag_we[w]),
            .tag_i       (ram_tag_wdata),
            .byte_we_i   (ram_byte_we),
            .line_i      (ram_line_wdata),
            .tag_o       (ram_tag[w]),
            .line_o      (ram_line[w]),
            .init_busy_o (ram_init_busy[w])
        );
    end

    // a miss answers from the refill line in the cycle it arrives
    assign data_ok_o = (s3_valid && s3_any_hit) || refill_i.valid;
    assign rdata_o   = refill_i.valid ? refill_i.line[s3_req.addr[3:2] * 32 +: 32]
                                      : hit_line[s3_req.addr[3:2] * 32 +: 32];

    assign s3_miss_o  = s3_valid && !s3_any_hit;
    assign s3_req_o   = s3_req;
    assign s3_tags_o  = s3_tags;
    assign s3_lines_o = s3_lines;

endmodule

//--- source/dcache_miss_fsm.sv
`timescale 1ns/1ps

module dcache_miss_fsm import dcache_pkg::*; #(
    parameter logic [15:0] LFSR_SEED = 16'hace1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   s3_miss_i,
    input  cpu_req_t               s3_req_i,
    input  tag_entry_t [NWAY-1:0]  s3_tags_i,
    input  line_t [NWAY-1:0]       s3_lines_i,
    output logic                   busy_o,
    output refill_t                refill_o,
    input  logic                   mem_ready_i,
    output logic                   mem_req_o,
    output mem_req_t               mem_req_data_o,
    input  logic                   mem_rvalid_i,
    input  logic                   mem_bvalid_i,
    input  line_t                  mem_rdata_i
);

    miss_state_t state, state_next;
    logic [15:0] lfsr;
    way_t        victim_way;
    way_t        pick_way;
    logic        pick_dirty;

    // free-running LFSR with taps at 16 14 13 11
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    assign pick_way   = way_t'(lfsr[0]);
    assign pick_dirty = s3_tags_i[pick_way].valid && s3_tags_i[pick_way].dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            victim_way <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE && s3_miss_i) begin
                victim_way <= pick_way;
            end
        end
    end

    always_comb begin
        state_next     = state;
        mem_req_o      = 1'b0;
        mem_req_data_o = '0;
        refill_o       = '0;
        case (state)
            IDLE: begin
                if (s3_miss_i) begin
                    state_next = pick_dirty ? EVICT_REQ : REFILL_REQ;
                end
            end
            EVICT_REQ: begin
                // victim address is its own tag with the missing set index
                mem_req_data_o.we    = 1'b1;
                mem_req_data_o.addr  = {s3_tags_i[victim_way].tag,
                                        s3_req_i.addr[OFFSET_W +: INDEX_W],
                                        {OFFSET_W{1'b0}}};
                mem_req_data_o.wdata = s3_lines_i[victim_way];
                if (mem_ready_i) begin
                    mem_req_o  = 1'b1;
                    state_next = EVICT_WAIT;
                end
            end
            EVICT_WAIT: begin
                if (mem_bvalid_i) begin
                    state_next = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_data_o.addr = {s3_req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                if (mem_ready_i) begin
                    mem_req_o  = 1'b1;
                    state_next = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_rvalid_i) begin
                    refill_o.valid = 1'b1;
                    refill_o.way   = victim_way;
                    // only a store miss leaves the new line dirty
                    refill_o.dirty = |s3_req_i.wstrb;
                    refill_o.line  = merge_store(mem_rdata_i, s3_req_i.addr,
                                                 s3_req_i.wstrb, s3_req_i.wdata);
                    state_next     = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // the miss itself must stall stage 3 in the cycle it shows up
    assign busy_o = (state != IDLE) || s3_miss_i;

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter logic [15:0] LFSR_SEED = 16'hace1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid_i,
    input  cpu_req_t req_i,
    output logic     ready_o,
    output logic     data_ok_o,
    output word_t    rdata_o,
    input  logic     mem_ready_i,
    output logic     mem_req_o,
    output mem_req_t mem_req_data_o,
    input  logic     mem_rvalid_i,
    input  logic     mem_bvalid_i,
    input  line_t    mem_rdata_i
);

    logic                  s3_miss;
    cpu_req_t              s3_req;
    tag_entry_t [NWAY-1:0] s3_tags;
    line_t [NWAY-1:0]      s3_lines;
    logic                  busy;
    refill_t               refill;

    dcache_pipeline u_pipeline (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .ready_o     (ready_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .busy_i      (busy),
        .refill_i    (refill),
        .s3_miss_o   (s3_miss),
        .s3_req_o    (s3_req),
        .s3_tags_o   (s3_tags),
        .s3_lines_o  (s3_lines)
    );

    dcache_miss_fsm #(
        .LFSR_SEED (LFSR_SEED)
    ) u_miss_fsm (
        .clk            (clk),
        .rst            (rst),
        .s3_miss_i      (s3_miss),
        .s3_req_i       (s3_req),
        .s3_tags_i      (s3_tags),
        .s3_lines_i     (s3_lines),
        .busy_o         (busy),
        .refill_o       (refill),
        .mem_ready_i    (mem_ready_i),
        .mem_req_o      (mem_req_o),
        .mem_req_data_o (mem_req_data_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_bvalid_i   (mem_bvalid_i),
        .mem_rdata_i    (mem_rdata_i)
    );

endmodule

//--- verification/dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties (
    input logic clk,
    input logic rst,
    input logic data_ok_i,
    input logic mem_ready_i,
    input logic mem_req_i,
    input logic mem_rvalid_i,
    input logic mem_bvalid_i
);

    // high from a memory request until its response pulse
    logic mem_outstanding;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_outstanding <= 1'b0;
        end else if (mem_req_i) begin
            mem_outstanding <= 1'b1;
        end else if (mem_rvalid_i || mem_bvalid_i) begin
            mem_outstanding <= 1'b0;
        end
    end

    req_needs_ready: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> mem_ready_i)
        else $error("mem_req_o raised while mem_ready_i is low");

    single_outstanding: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> !mem_outstanding)
        else $error("mem_req_o raised while a memory request is outstanding");

    data_ok_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(data_ok_i))
        else $error("data_ok_o is unknown after reset");

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int unsigned SEED = 32'h4523_9b1c;
    localparam int NUM_REQS       = 800;
    localparam int SWEEP_TIMEOUT  = 300;
    localparam int ACCEPT_TIMEOUT = 400;
    localparam int DRAIN_TIMEOUT  = 800;

    logic     clk;
    logic     rst;
    logic     req_valid_i;
    cpu_req_t req_i;
    logic     ready_o;
    logic     data_ok_o;
    word_t    rdata_o;
    logic     mem_ready_i;
    logic     mem_req_o;
    mem_req_t mem_req_data_o;
    logic     mem_rvalid_i;
    logic     mem_bvalid_i;
    line_t    mem_rdata_i;

    // backing memory by line address, and the byte-wide reference model
    line_t       mem_lines [addr_t];
    logic [7:0]  model_mem [addr_t];
    cpu_req_t    pending [$];
    addr_t       line_addrs [$];
    tag_t        tags [6];
    index_t      sets [4];
    logic        accepted;
    logic        mem_pending;
    logic        mem_is_write;
    addr_t       mem_addr;
    int          mem_delay;
    int          responses;
    int unsigned seed_dummy;
    cpu_req_t    rd_req;

    dcache_top #(
        .LFSR_SEED (16'h5a3c)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .ready_o        (ready_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .mem_ready_i    (mem_ready_i),
        .mem_req_o      (mem_req_o),
        .mem_req_data_o (mem_req_data_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_bvalid_i   (mem_bvalid_i),
        .mem_rdata_i    (mem_rdata_i)
    );

    bind dcache_top dcache_properties u_properties (
        .clk          (clk),
        .rst          (rst),
        .data_ok_i    (data_ok_o),
        .mem_ready_i  (mem_ready_i),
        .mem_req_i    (mem_req_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_bvalid_i (mem_bvalid_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // first touch of a line fills memory and model with the same random bytes
    function automatic void touch_line(addr_t a);
        addr_t la;
        line_t l;
        la = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        if (!mem_lines.exists(la)) begin
            l = {$urandom(), $urandom(), $urandom(), $urandom()};
            mem_lines[la] = l;
            for (int b = 0; b < 16; b++) begin
                model_mem[la + addr_t'(b)] = l[b * 8 +: 8];
            end
        end
    endfunction

    function automatic word_t model_word(addr_t a);
        addr_t base;
        word_t w;
        base = {a[ADDR_W-1:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[b * 8 +: 8] = model_mem[base + addr_t'(b)];
        end
        return w;
    endfunction

    function automatic line_t model_line(addr_t la);
        line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b * 8 +: 8] = model_mem[la + addr_t'(b)];
        end
        return l;
    endfunction

    function automatic void apply_store(cpu_req_t r);
        addr_t base;
        base = {r.addr[ADDR_W-1:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (r.wstrb[b]) begin
                model_mem[base + addr_t'(b)] = r.wdata[b * 8 +: 8];
            end
        end
    endfunction

    // aligned byte, half-word and word strobes over a small set of lines
    function automatic cpu_req_t random_req();
        cpu_req_t   r;
        int         ti;
        int         si;
        logic [1:0] lane;
        ti = $urandom_range(5);
        si = $urandom_range(3);
        lane = 2'($urandom_range(3));
        r.addr  = {tags[ti], sets[si], 2'($urandom_range(3)), 2'b00};
        r.wdata = $urandom();
        case ($urandom_range(5))
            0, 1: r.wstrb = 4'b0000;
            2: begin
                r.wstrb     = strb_t'(4'b0001 << lane);
                r.addr[1:0] = lane;
            end
            3: begin
                r.wstrb     = lane[1] ? 4'b1100 : 4'b0011;
                r.addr[1:0] = {lane[1], 1'b0};
            end
            default: r.wstrb = 4'b1111;
        endcase
        return r;
    endfunction

    // outputs are settled at the falling edge, before the next rising edge
    task automatic observe();
        cpu_req_t r;
        cpu_req_t oldest;
        addr_t    miss_la;
        if (data_ok_o) begin
            if (pending.size() == 0) begin
                stop_run("data_ok_o pulsed with no request outstanding");
            end else begin
                r = pending.pop_front();
                if (r.wstrb == '0) begin
                    check_word("rdata_o", rdata_o, model_word(r.addr));
                end else begin
                    apply_store(r);
                end
                responses++;
            end
        end
        if (req_valid_i && ready_o) begin
            touch_line(req_i.addr);
            pending.push_back(req_i);
            accepted = 1'b1;
        end
        if (mem_req_o) begin
            if (mem_pending) begin
                stop_run("memory request issued while another one is outstanding");
            end else if (!mem_ready_i) begin
                stop_run("memory request issued while mem_ready_i is low");
            end else if (pending.size() == 0) begin
                stop_run("memory request issued with no request outstanding");
            end
            // the oldest open request waits in stage 3 and owns the miss
            oldest  = pending[0];
            miss_la = {oldest.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            if (mem_req_data_o.we) begin
                // the victim line lives in the set of the missing line
                check_addr("mem_req_data_o.addr", mem_req_data_o.addr,
                           {mem_req_data_o.addr[ADDR_W-1 -: TAG_W],
                            miss_la[INDEX_W+OFFSET_W-1:0]});
                if (!mem_lines.exists(mem_req_data_o.addr)) begin
                    stop_run("write-back to a line that was never accessed");
                end
                check_line("mem_req_data_o.wdata", mem_req_data_o.wdata,
                           model_line(mem_req_data_o.addr));
                mem_lines[mem_req_data_o.addr] = mem_req_data_o.wdata;
            end else begin
                check_addr("mem_req_data_o.addr", mem_req_data_o.addr, miss_la);
            end
            mem_pending  = 1'b1;
            mem_is_write = mem_req_data_o.we;
            mem_addr     = mem_req_data_o.addr;
            mem_delay    = $urandom_range(8, 1);
        end
    endtask

    // observe at the falling edge and drive the memory side at the rising one
    task automatic cycle();
        @(negedge clk);
        observe();
        @(posedge clk);
        mem_rvalid_i <= 1'b0;
        mem_bvalid_i <= 1'b0;
        if (mem_pending) begin
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                if (mem_is_write) begin
                    mem_bvalid_i <= 1'b1;
                end else begin
                    mem_rvalid_i <= 1'b1;
                    mem_rdata_i  <= mem_lines[mem_addr];
                end
                mem_pending = 1'b0;
            end
        end
        mem_ready_i <= !mem_pending && ($urandom_range(3) != 0);
    endtask

    task automatic send(cpu_req_t r);
        int waited;
        waited = 0;
        req_valid_i <= 1'b1;
        req_i       <= r;
        accepted = 1'b0;
        while (!accepted) begin
            if (waited == ACCEPT_TIMEOUT) begin
                stop_run("request was not accepted before the timeout");
            end
            cycle();
            waited++;
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            if (mem_req_o) begin
                stop_run("mem_req_o is high before ready_o rises after reset");
            end
            if (data_ok_o) begin
                stop_run("data_ok_o is high before ready_o rises after reset");
            end
            waited++;
            if (waited > SWEEP_TIMEOUT) begin
                stop_run("ready_o did not rise after reset");
            end
        end while (!ready_o);
        @(posedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        req_valid_i <= 1'b0;
        while (pending.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                stop_run("responses still missing at the drain timeout");
            end
            cycle();
            waited++;
        end
        // a stray response in these cycles is caught by observe
        repeat (4) cycle();
    endtask

    initial begin
        seed_dummy = $urandom(SEED);
        rst          <= 1'b1;
        req_valid_i  <= 1'b0;
        req_i        <= '0;
        mem_ready_i  <= 1'b0;
        mem_rvalid_i <= 1'b0;
        mem_bvalid_i <= 1'b0;
        mem_rdata_i  <= '0;
        mem_pending = 1'b0;
        responses   = 0;
        for (int i = 0; i < 4; i++) begin
            sets[i] = index_t'($urandom());
        end
        for (int i = 0; i < 6; i++) begin
            tags[i] = tag_t'($urandom());
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        wait_ready();

        // random traffic with idle gaps
        for (int n = 0; n < NUM_REQS; n++) begin
            if ($urandom_range(3) == 0) begin
                req_valid_i <= 1'b0;
                cycle();
            end
            send(random_req());
        end
        drain();

        // read back every word of every touched line
        foreach (mem_lines[a]) begin
            line_addrs.push_back(a);
        end
        foreach (line_addrs[i]) begin
            for (int w = 0; w < 4; w++) begin
                rd_req.addr  = line_addrs[i] + addr_t'(w * 4);
                rd_req.wstrb = '0;
                rd_req.wdata = '0;
                send(rd_req);
            end
        end
        drain();

        $display("%0d responses checked", responses);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- list.f
source/dcache_pkg.sv
source/dcache_way_ram.sv
source/dcache_pipeline.sv
source/dcache_miss_fsm.sv
source/dcache_top.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module dcache_tb -f list.f -o dcache_sim &&
./obj_dir/dcache_sim ||
exit 1
